// File: files.f
hdl/oq_pkg.sv
hdl/oq_line_fifo.sv
hdl/oq_conf_decoder.sv
hdl/oq_queue_ctrl.sv
hdl/oq_write_arbiter.sv
hdl/oq_top.sv
verif/oq_mem_model.sv
verif/oq_tb.sv

// File: Bender.yml
package:
  name: oq_out_queue

sources:
  - hdl/oq_pkg.sv
  - hdl/oq_line_fifo.sv
  - hdl/oq_conf_decoder.sv
  - hdl/oq_queue_ctrl.sv
  - hdl/oq_write_arbiter.sv
  - hdl/oq_top.sv
  - target: test
    files:
      - verif/oq_mem_model.sv
      - verif/oq_tb.sv

// File: verif/oq_tb.sv
module oq_tb
  import oq_pkg::*;
();

  logic                             clk;
  logic                             rst_internal;
  logic                             start;
  logic [CONF_TYPE_W-1:0]           conf_valid;
  conf_t                            conf;
  logic [NUM_QUEUES-1:0]            acc_write;
  line_t                            acc_data [NUM_QUEUES];
  logic [NUM_QUEUES-1:0]            acc_done;
  logic                             mem_ready;
  wr_ack_t                          mem_ack;
  logic [NUM_QUEUES-1:0]            acc_ready;
  logic                             mem_valid;
  wr_req_t                          mem_req;
  logic [NUM_QUEUES-1:0]            has_wr_pending;
  logic [NUM_QUEUES-1:0]            done;
  logic [NUM_QUEUES-1:0][QTD_W-1:0] unacked;
  int unsigned                      wr_total;
  logic [31:0]                      lfsr = 32'hdd6;
  logic                             stall = 1'b0;
  logic [NUM_QUEUES-1:0]            write_en_rand = '0;
  logic [ADDR_W-1:0]                exp_base [NUM_QUEUES] = '{default: '0};
  int unsigned                      exp_qtd [NUM_QUEUES] = '{default: 0};
  int unsigned                      wr_idx [NUM_QUEUES] = '{default: 0};
  int unsigned                      acked_seen [NUM_QUEUES] = '{default: 0};

  oq_top i_dut (.*);
  oq_mem_model i_mem (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // accelerator line as queue id over line index
  function automatic line_t make_line(input int q, input int unsigned i);
    return {32'(q), 32'(i)};
  endfunction

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin : rand_gen
    stall <= lfsr[0];
    lfsr = lfsr_next(lfsr);
    for (int q = 0; q < NUM_QUEUES; q++) begin
      write_en_rand[q] <= lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  end

  always @(posedge clk) begin : mem_check
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] exp_addr;
    line_t             exp_data;
    int unsigned       k;
    if (!rst_internal) begin
      if (conf_valid == CONF_TYPE_OUT && conf.queue_id < NUM_QUEUES) begin  // fresh run
        exp_base[conf.queue_id]   = conf.addr_base;
        exp_qtd[conf.queue_id]    = conf.qtd_lines;
        wr_idx[conf.queue_id]     = 0;
        acked_seen[conf.queue_id] = 0;
      end
      assert (mem_ready || !mem_valid) else begin
        $display("mem_valid was high while mem_ready was low at t=%0t", $time);
        fail_run();
      end
      if (mem_valid) begin
        tag = mem_req.tag;
        assert (tag < NUM_QUEUES && wr_idx[tag] < (exp_qtd[tag] + 3) / 4 * 4) else begin
          $display("unexpected memory write with tag %0d at t=%0t", tag, $time);
          fail_run();
        end
        k        = wr_idx[tag];
        exp_addr = exp_base[tag] + k;
        exp_data = (k < exp_qtd[tag]) ? make_line(tag, k) : '0;  // pad lines are zero
        assert (mem_req.addr == exp_addr) else begin
          $display("FAILED t=%0t mem_req.addr expected %h got %h", $time, exp_addr, mem_req.addr);
          fail_run();
        end
        assert (mem_req.data == exp_data) else begin
          $display("FAILED t=%0t mem_req.data expected %h got %h", $time, exp_data, mem_req.data);
          fail_run();
        end
        wr_idx[tag] = k + 1;
      end
      for (int q = 0; q < NUM_QUEUES; q++) begin
        assert (!done[q] || acked_seen[q] >= exp_qtd[q]) else begin
          $display("FAILED t=%0t done[%0d] expected 0 got 1", $time, q);
          fail_run();
        end
        assert (unacked[q] == '0 || has_wr_pending[q]) else begin
          $display("FAILED t=%0t has_wr_pending[%0d] expected 1 got 0", $time, q);
          fail_run();
        end
      end
      if (mem_ack.valid && mem_ack.tag < NUM_QUEUES) acked_seen[mem_ack.tag] += ACK_LINES;
    end
  end

  task automatic send_conf(input logic [CONF_TYPE_W-1:0] kind, input logic [ADDR_W-1:0] base,
                           input int qtd, input int id);
    @(posedge clk);
    conf_valid <= kind;
    conf       <= '{addr_base: base, qtd_lines: QTD_W'(qtd), queue_id: CONF_ID_W'(id)};
    @(posedge clk);
    conf_valid <= '0;
  endtask

  task automatic feed_lines(input int q, input int first, input int last);
    int i;
    int guard;
    i     = first;
    guard = 0;
    while (i < last) begin
      @(posedge clk);
      guard++;
      if (guard > 1000) begin
        $display("timeout while feeding lines into queue %0d", q);
        fail_run();
      end
      if (acc_ready[q] && write_en_rand[q]) begin  // ready as seen in the previous cycle
        acc_write[q] <= 1'b1;
        acc_data[q]  <= make_line(q, i);
        i++;
      end else begin
        acc_write[q] <= 1'b0;
      end
    end
    @(posedge clk);
    acc_write[q] <= 1'b0;
  endtask

  // writes every cycle until acc_ready drops
  task automatic fill_until_stall(input int q, output int n);
    int guard;
    n     = 0;
    guard = 0;
    do begin
      @(posedge clk);
      guard++;
      acc_write[q] <= acc_ready[q];
      acc_data[q]  <= make_line(q, n);
      if (acc_ready[q]) n++;
    end while (acc_ready[q] && guard < 64);
    if (acc_ready[q]) begin
      $display("acc_ready of queue %0d never fell while the FIFO was filling", q);
      fail_run();
    end
    assert (n <= 2 ** LINE_FIFO_BITS) else begin
      $display("FAILED t=%0t lines accepted by acc_ready expected <= %0d got %0d",
               $time, 2 ** LINE_FIFO_BITS, n);
      fail_run();
    end
  endtask

  task automatic wait_idle(input int q);
    int guard;
    guard = 0;
    while (!done[q] || has_wr_pending[q]) begin
      @(posedge clk);
      guard++;
      if (guard > 2000) begin
        $display("timeout waiting for queue %0d to finish its writes", q);
        fail_run();
      end
    end
  endtask

  task automatic wait_cleared(input int q);
    int guard;
    guard = 0;
    while (done[q] || has_wr_pending[q]) begin
      @(posedge clk);
      guard++;
      if (guard > 16) begin
        $display("soft reset did not clear done and has_wr_pending of queue %0d", q);
        fail_run();
      end
    end
  endtask

  task automatic check_count(input int q, input int unsigned n);
    assert (wr_idx[q] == n) else begin
      $display("FAILED t=%0t writes of tag %0d expected %0d got %0d", $time, q, n, wr_idx[q]);
      fail_run();
    end
  endtask

  initial begin : stimulus
    int n;
    rst_internal = 1'b1;
    start        = 1'b0;
    conf_valid   = '0;
    conf         = '0;
    acc_write    = '0;
    acc_data     = '{default: '0};
    acc_done     = '0;
    repeat (3) @(posedge clk);
    rst_internal <= 1'b0;

    // both queues under random back-pressure with queue 1 padded to 8
    send_conf(CONF_TYPE_OUT, 32'h100, 8, 0);
    send_conf(CONF_TYPE_OUT, 32'h200, 6, 1);
    start <= 1'b1;
    fork
      feed_lines(0, 0, 8);
      feed_lines(1, 0, 6);
    join
    acc_done <= '1;
    wait_idle(0);
    wait_idle(1);
    check_count(0, 8);
    check_count(1, 8);

    // soft reset and then a longer run that first fills the FIFO with start low
    start    <= 1'b0;
    acc_done <= '0;
    send_conf(CONF_TYPE_RESET, '0, 0, 0);
    wait_cleared(0);
    send_conf(CONF_TYPE_OUT, 32'h300, 16, 0);
    fill_until_stall(0, n);
    start <= 1'b1;
    feed_lines(0, n, 16);
    acc_done[0] <= 1'b1;
    wait_idle(0);
    check_count(0, 16);
    assert (wr_total == 32) else begin
      $display("FAILED t=%0t wr_total expected 32 got %0d", $time, wr_total);
      fail_run();
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: verif/oq_mem_model.sv
module oq_mem_model
  import oq_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_internal,
  input  logic                             stall,
  input  logic                             mem_valid,
  input  wr_req_t                          mem_req,
  output logic                             mem_ready,
  output wr_ack_t                          mem_ack,
  output logic [NUM_QUEUES-1:0][QTD_W-1:0] unacked,
  output int unsigned                      wr_total
);

  logic                                          ready_q = 1'b0;
  wr_ack_t                                       ack_q   = '0;
  logic [NUM_QUEUES-1:0][$clog2(ACK_LINES)-1:0]  group;

  assign mem_ready = ready_q;
  assign mem_ack   = ack_q;

  always @(posedge clk) begin
    if (rst_internal) begin
      ready_q  <= 1'b0;
      ack_q    <= '0;
      unacked  <= '0;
      group    <= '0;
      wr_total <= 0;
    end else begin
      ready_q <= ~stall;  // random back-pressure
      ack_q   <= '0;
      if (mem_valid && mem_req.tag < NUM_QUEUES) begin
        wr_total <= wr_total + 1;
        if (group[mem_req.tag] == ($clog2(ACK_LINES))'(ACK_LINES - 1)) begin  // group complete
          group[mem_req.tag]   <= '0;
          ack_q                <= '{valid: 1'b1, tag: mem_req.tag};
          unacked[mem_req.tag] <= unacked[mem_req.tag] - QTD_W'(ACK_LINES - 1);
        end else begin
          group[mem_req.tag]   <= group[mem_req.tag] + 1'b1;
          unacked[mem_req.tag] <= unacked[mem_req.tag] + 1'b1;
        end
      end
    end
  end

endmodule

// File: hdl/oq_top.sv
module oq_top
  import oq_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_internal,
  input  logic                   start,
  input  logic [CONF_TYPE_W-1:0] conf_valid,
  input  conf_t                  conf,
  input  logic [NUM_QUEUES-1:0]  acc_write,
  input  line_t                  acc_data [NUM_QUEUES],
  input  logic [NUM_QUEUES-1:0]  acc_done,
  input  logic                   mem_ready,
  input  wr_ack_t                mem_ack,
  output logic [NUM_QUEUES-1:0]  acc_ready,
  output logic                   mem_valid,
  output wr_req_t                mem_req,
  output logic [NUM_QUEUES-1:0]  has_wr_pending,
  output logic [NUM_QUEUES-1:0]  done
);

  logic [NUM_QUEUES-1:0] conf_out_valid;
  logic [NUM_QUEUES-1:0] soft_rst;
  logic [NUM_QUEUES-1:0] grant;
  logic [NUM_QUEUES-1:0] req_valid;
  conf_t                 conf_out [NUM_QUEUES];
  wr_req_t               req [NUM_QUEUES];

  for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
    oq_conf_decoder #(
      .QUEUE_ID(q)
    ) i_conf_decoder (
      .clk           (clk),
      .rst_internal  (rst_internal),
      .conf_valid    (conf_valid),
      .conf          (conf),
      .conf_out_valid(conf_out_valid[q]),
      .conf_out      (conf_out[q]),
      .soft_rst      (soft_rst[q])
    );

    oq_queue_ctrl #(
      .QUEUE_ID(q)
    ) i_queue_ctrl (
      .clk           (clk),
      .rst_internal  (rst_internal),
      .soft_rst      (soft_rst[q]),
      .start         (start),
      .conf_out_valid(conf_out_valid[q]),
      .conf_out      (conf_out[q]),
      .grant         (grant[q]),
      .acc_write     (acc_write[q]),
      .acc_data      (acc_data[q]),
      .acc_done      (acc_done[q]),
      .mem_ack       (mem_ack),
      .acc_ready     (acc_ready[q]),
      .req_valid     (req_valid[q]),
      .req           (req[q]),
      .has_wr_pending(has_wr_pending[q]),
      .done          (done[q])
    );
  end

  oq_write_arbiter i_write_arbiter (
    .clk         (clk),
    .rst_internal(rst_internal),
    .req_valid   (req_valid),
    .req         (req),
    .mem_ready   (mem_ready),
    .grant       (grant),
    .mem_valid   (mem_valid),
    .mem_req     (mem_req)
  );

endmodule

// File: hdl/oq_write_arbiter.sv
module oq_write_arbiter
  import oq_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_internal,
  input  logic [NUM_QUEUES-1:0] req_valid,
  input  wr_req_t               req [NUM_QUEUES],
  input  logic                  mem_ready,
  output logic [NUM_QUEUES-1:0] grant,
  output logic                  mem_valid,
  output wr_req_t               mem_req
);

  logic [$clog2(NUM_QUEUES)-1:0] rr_ptr;
  logic [SKID_FIFO_BITS:0]       skid_count;
  logic [SKID_FIFO_BITS:0]       skid_next;
  logic                          skid_empty;
  logic                          skid_valid;
  logic                          skid_re;
  logic                          push;
  wr_req_t                       push_req;
  wr_req_t                       skid_dout;
  logic                          out_valid;

  // grants are exclusive, so at most one queue pushes per cycle
  always_comb begin
    push_req = req[0];
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (req_valid[q]) push_req = req[q];
    end
  end

  assign push      = |req_valid;
  assign skid_re   = mem_ready & ~skid_empty & ~skid_valid;
  assign skid_next = skid_count + push - skid_re;  // occupancy seen next cycle

  oq_line_fifo #(
    .payload_t        (wr_req_t),
    .DEPTH_BITS       (SKID_FIFO_BITS),
    .ALMOSTFULL_MARGIN(1)
  ) i_skid_fifo (
    .clk         (clk),
    .rst_internal(rst_internal),
    .we          (push),
    .din         (push_req),
    .re          (skid_re),
    .valid       (skid_valid),
    .dout        (skid_dout),
    .count       (skid_count),
    .empty       (skid_empty),
    .full        (),
    .almost_full (),
    .almost_empty()
  );

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      grant  <= '0;
      rr_ptr <= '0;
    end else begin
      grant <= '0;
      if (skid_next <= 1) begin  // room for the two lines still in flight
        grant[rr_ptr] <= 1'b1;
        rr_ptr <= (rr_ptr == NUM_QUEUES - 1) ? '0 : rr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      out_valid <= 1'b0;
    end else if (skid_valid) begin
      out_valid <= 1'b1;
    end else if (mem_valid) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (skid_valid) mem_req <= skid_dout;
  end

  assign mem_valid = out_valid & mem_ready;  // head line taken by memory

endmodule

// File: hdl/oq_queue_ctrl.sv
module oq_queue_ctrl
  import oq_pkg::*;
#(
  parameter int QUEUE_ID = 0
) (
  input  logic    clk,
  input  logic    rst_internal,
  input  logic    soft_rst,
  input  logic    start,
  input  logic    conf_out_valid,
  input  conf_t   conf_out,
  input  logic    grant,
  input  logic    acc_write,
  input  line_t   acc_data,
  input  logic    acc_done,
  input  wr_ack_t mem_ack,
  output logic    acc_ready,
  output logic    req_valid,
  output wr_req_t req,
  output logic    has_wr_pending,
  output logic    done
);

  logic              q_rst;
  logic              conf_ready;
  logic              addr_init;
  logic [ADDR_W-1:0] addr_base;
  logic [ADDR_W-1:0] addr_next;
  logic [QTD_W-1:0]  qtd_lines;
  logic [QTD_W-1:0]  issued;
  logic [QTD_W-1:0]  pending;
  logic [QTD_W-1:0]  acked;
  logic              run;
  logic              lines_left;
  logic              pop;
  logic              pop_q;
  logic              pad;
  logic              pad_q;
  logic              issue;
  logic              ack_hit;
  logic [ADDR_W-1:0] addr_q;
  logic              fifo_valid;
  line_t             fifo_dout;
  logic              fifo_empty;
  logic              fifo_almost_full;
  logic              fifo_almost_empty;

  assign q_rst      = rst_internal | soft_rst;
  assign run        = grant & start & conf_ready & ~addr_init;
  assign lines_left = issued < qtd_lines;
  // no back-to-back pops near empty
  assign pop        = run & lines_left & ~fifo_empty & (~fifo_almost_empty | ~pop_q);
  assign pad        = run & ~lines_left & fifo_empty & acc_done &
                      ((issued % QTD_W'(ACK_LINES)) != '0);
  assign issue      = pop | pad;
  assign ack_hit    = mem_ack.valid & (mem_ack.tag == TAG_W'(QUEUE_ID));

  oq_line_fifo #(
    .payload_t        (line_t),
    .DEPTH_BITS       (LINE_FIFO_BITS),
    .ALMOSTFULL_MARGIN(4)
  ) i_line_fifo (
    .clk         (clk),
    .rst_internal(q_rst),
    .we          (acc_write),
    .din         (acc_data),
    .re          (pop),
    .valid       (fifo_valid),
    .dout        (fifo_dout),
    .count       (),
    .empty       (fifo_empty),
    .full        (),
    .almost_full (fifo_almost_full),
    .almost_empty(fifo_almost_empty)
  );

  always_ff @(posedge clk) begin
    if (q_rst) begin
      conf_ready <= 1'b0;
      addr_base  <= '0;
      qtd_lines  <= '0;
    end else if (conf_out_valid) begin
      conf_ready <= 1'b1;
      addr_base  <= conf_out.addr_base;
      qtd_lines  <= conf_out.qtd_lines;
    end
  end

  always_ff @(posedge clk) begin
    if (q_rst) begin
      addr_next <= '0;
      addr_init <= 1'b1;
    end else if (conf_ready && addr_init) begin
      addr_next <= addr_base;  // first line goes to the base
      addr_init <= 1'b0;
    end else if (issue) begin
      addr_next <= addr_next + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (q_rst) begin
      acc_ready      <= 1'b0;
      pop_q          <= 1'b0;
      pad_q          <= 1'b0;
      req_valid      <= 1'b0;
      issued         <= '0;
      acked          <= '0;
      has_wr_pending <= 1'b0;
      done           <= 1'b0;
    end else begin
      acc_ready      <= ~fifo_almost_full;
      pop_q          <= pop;
      pad_q          <= pad;
      req_valid      <= fifo_valid | pad_q;  // two cycles after the issue
      has_wr_pending <= pending != '0;
      if (issue) issued <= issued + 1'b1;
      if (ack_hit) acked <= acked + QTD_W'(ACK_LINES);
      if (conf_ready && acked >= qtd_lines) done <= 1'b1;  // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    if (q_rst) begin
      pending <= '0;
    end else begin
      case ({ack_hit, issue})
        2'b01:   pending <= pending + 1'b1;
        2'b10:   pending <= pending - QTD_W'(ACK_LINES);
        2'b11:   pending <= pending - QTD_W'(ACK_LINES - 1);
        default: pending <= pending;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) addr_q <= addr_next;
    req.data <= pad_q ? '0 : fifo_dout;
    req.addr <= addr_q;
    req.tag  <= TAG_W'(QUEUE_ID);
  end

endmodule

// File: hdl/oq_conf_decoder.sv
module oq_conf_decoder
  import oq_pkg::*;
#(
  parameter int QUEUE_ID = 0
) (
  input  logic                   clk,
  input  logic                   rst_internal,
  input  logic [CONF_TYPE_W-1:0] conf_valid,
  input  conf_t                  conf,
  output logic                   conf_out_valid,
  output conf_t                  conf_out,
  output logic                   soft_rst
);

  logic id_hit;
  logic out_hit;
  logic rst_hit;

  assign id_hit  = conf.queue_id == CONF_ID_W'(QUEUE_ID);
  assign out_hit = (conf_valid == CONF_TYPE_OUT) & id_hit;
  assign rst_hit = (conf_valid == CONF_TYPE_RESET) & id_hit;

  // one-cycle strobes one cycle after the word
  always_ff @(posedge clk) begin
    if (rst_internal) begin
      conf_out_valid <= 1'b0;
      soft_rst       <= 1'b0;
    end else begin
      conf_out_valid <= out_hit;
      soft_rst       <= rst_hit;
    end
  end

  // last accepted output configuration
  always_ff @(posedge clk) begin
    if (out_hit) begin
      conf_out <= conf;
    end
  end

endmodule

// File: hdl/oq_line_fifo.sv
module oq_line_fifo
  import oq_pkg::*;
#(
  parameter type payload_t         = logic,
  parameter int  DEPTH_BITS        = 4,
  parameter int  ALMOSTFULL_MARGIN = 4
) (
  input  logic              clk,
  input  logic              rst_internal,
  input  logic              we,
  input  payload_t          din,
  input  logic              re,
  output logic              valid,
  output payload_t          dout,
  output logic [DEPTH_BITS:0] count,
  output logic              empty,
  output logic              full,
  output logic              almost_full,
  output logic              almost_empty
);

  payload_t                mem [2**DEPTH_BITS];
  logic [DEPTH_BITS-1:0]   wr_ptr;
  logic [DEPTH_BITS-1:0]   rd_ptr;
  logic                    do_write;
  logic                    do_read;

  assign do_write = we & ~full;  // writes into a full buffer are dropped
  assign do_read  = re & ~empty;

  assign empty        = count == '0;
  assign full         = count == (DEPTH_BITS+1)'(2 ** DEPTH_BITS);
  assign almost_full  = count >= (DEPTH_BITS+1)'(2 ** DEPTH_BITS - ALMOSTFULL_MARGIN);
  assign almost_empty = count <= (DEPTH_BITS+1)'(FIFO_AE_LEVEL);

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      valid  <= 1'b0;
      count  <= '0;
    end else begin
      valid <= do_read;
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
    if (do_read) begin
      dout <= mem[rd_ptr];  // registered read that lands with valid
    end
  end

endmodule

// File: hdl/oq_pkg.sv
package oq_pkg;

  // widths and counts
  localparam int ADDR_W         = 32;
  localparam int QTD_W          = 16;
  localparam int DATA_W         = 64;
  localparam int TAG_W          = 4;
  localparam int CONF_ID_W      = 8;
  localparam int CONF_TYPE_W    = 2;
  localparam int NUM_QUEUES     = 2;
  localparam int ACK_LINES      = 4;  // lines covered by one memory ack
  localparam int LINE_FIFO_BITS = 4;
  localparam int SKID_FIFO_BITS = 2;
  localparam int FIFO_AE_LEVEL  = 2;  // almost-empty at or below this count

  // configuration word types with zero as idle
  localparam logic [CONF_TYPE_W-1:0] CONF_TYPE_RESET = 2'd1;
  localparam logic [CONF_TYPE_W-1:0] CONF_TYPE_OUT   = 2'd2;

  typedef logic [DATA_W-1:0] line_t;

  typedef struct packed {
    logic [ADDR_W-1:0]    addr_base;
    logic [QTD_W-1:0]     qtd_lines;
    logic [CONF_ID_W-1:0] queue_id;
  } conf_t;  // 56 bits

  typedef struct packed {
    line_t             data;
    logic [ADDR_W-1:0] addr;
    logic [TAG_W-1:0]  tag;
  } wr_req_t;  // 100 bits

  // broadcast to all queues as one pulse per ACK_LINES lines of a tag
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } wr_ack_t;

endpackage
